/* common/ifu_pkg.sv */
// instruction fetch front end package
// memory geometry, reset vector, fsm encodings, AXI-lite channel payloads,
// fetch output payload and the RV32 instruction views used by the predecoder

package ifu_pkg;

    // ========================================
    // geometry and constants
    // ========================================
    localparam int addr_w    = 32;
    localparam int data_w    = 32;
    localparam int strb_w    = data_w / 8;
    localparam int mem_words = 1024;
    // word index width, taken from addr bits above the byte offset
    localparam int mem_idx_w = $clog2(mem_words);

    localparam logic [addr_w-1:0] pc_rst    = 32'h8000_0000;
    localparam logic [1:0]        resp_okay = 2'b00;

    // rv32 major opcodes
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;

    // sram fsm states, shared by read and write side
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_busy = 2'd1;
    localparam logic [1:0] st_done = 2'd2;

    // ========================================
    // AXI-lite channel payloads
    // ========================================
    typedef struct packed {
        logic [addr_w-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [1:0]        resp;
    } axi_r_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    // pc / instruction pair toward decode
    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [data_w-1:0] inst;
    } fetch_out_t;

    // ========================================
    // instruction word views
    // ========================================
    // J layout, jal
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_j_fmt_t;

    // B layout, conditional branches
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } rv_b_fmt_t;

    typedef union packed {
        logic [data_w-1:0] raw;
        rv_j_fmt_t         j;
        rv_b_fmt_t         b;
    } rv_inst_u;

endpackage

/* sram/ifu_sram.sv */
// on-chip instruction sram, AXI-lite slave
// independent read and write fsms (idle / busy / done), one transfer each
// writes honour byte strobes, responses are always OKAY

`timescale 1ns/1ps

module ifu_sram (
    input  logic            clk,
    input  logic            rst,
    // read address
    input  ifu_pkg::axi_ar_t ar,
    input  logic            ar_valid,
    output logic            ar_ready,
    // read data
    output ifu_pkg::axi_r_t r,
    output logic            r_valid,
    input  logic            r_ready,
    // write address
    input  ifu_pkg::axi_aw_t aw,
    input  logic            aw_valid,
    output logic            aw_ready,
    // write data
    input  ifu_pkg::axi_w_t w,
    input  logic            w_valid,
    output logic            w_ready,
    // write response
    output ifu_pkg::axi_b_t b,
    output logic            b_valid,
    input  logic            b_ready
);

    import ifu_pkg::*;

    // storage, no reset on the array
    logic [data_w-1:0] mem [mem_words];

    // ========================================
    // read side
    // ========================================
    logic [1:0]           r_state;
    logic [1:0]           r_state_nxt;
    logic [mem_idx_w-1:0] r_idx;
    logic [data_w-1:0]    rdata_q;

    always_comb begin
        r_state_nxt = r_state;
        case (r_state)
            st_idle: if (ar_valid) r_state_nxt = st_busy;
            // array answers in one cycle
            st_busy: r_state_nxt = st_done;
            st_done: if (r_ready) r_state_nxt = st_idle;
            default: r_state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r_state <= st_idle;
        end else begin
            r_state <= r_state_nxt;
        end
    end

    // capture word index on AR transfer
    always_ff @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            r_idx <= ar.addr[mem_idx_w+1:2];
        end
    end

    // latch word at busy -> done
    always_ff @(posedge clk) begin
        if (r_state == st_busy) begin
            rdata_q <= mem[r_idx];
        end
    end

    assign ar_ready = (r_state == st_idle);
    assign r_valid  = (r_state == st_done);
    assign r.data   = rdata_q;
    assign r.resp   = resp_okay;

    // ========================================
    // write side
    // ========================================
    logic [1:0]           w_state;
    logic [1:0]           w_state_nxt;
    logic [mem_idx_w-1:0] w_idx;
    // strobes widened to one bit per data bit
    logic [data_w-1:0]    w_mask;

    always_comb begin
        w_state_nxt = w_state;
        case (w_state)
            st_idle: if (aw_valid) w_state_nxt = st_busy;
            st_busy: if (w_valid) w_state_nxt = st_done;
            st_done: if (b_ready) w_state_nxt = st_idle;
            default: w_state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            w_state <= st_idle;
        end else begin
            w_state <= w_state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_valid && aw_ready) begin
            w_idx <= aw.addr[mem_idx_w+1:2];
        end
    end

    // byte lanes, only strobed bytes change
    always_ff @(posedge clk) begin
        if (w_valid && w_ready) begin
            for (int i = 0; i < strb_w; i++) begin
                if (w.strb[i]) begin
                    mem[w_idx][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < strb_w; i++) begin
            w_mask[8*i +: 8] = {8{w.strb[i]}};
        end
    end

    assign aw_ready = (w_state == st_idle);
    assign w_ready  = (w_state == st_busy);
    assign b_valid  = (w_state == st_done);
    assign b.resp   = resp_okay;

    // ========================================
    // checks
    // ========================================
    // read data held until the master takes it
    a_r_stable: assert property (@(posedge clk) disable iff (rst)
        r_valid && !r_ready |=> $stable(r) && r_valid);

    // W lands in the addressed word, strobed lanes carry the new bytes
    a_w_in_busy: assert property (@(posedge clk) disable iff (rst)
        w_valid && w_ready |=> b_valid
            && ((mem[w_idx] ^ $past(w.data)) & $past(w_mask)) == '0);

endmodule

/* source/ifu_predecode.sv */
// static predecoder
// reads one instruction word in both the J and the B layout and picks
// the predicted next pc: jal target, backward branch target or pc + 4

`timescale 1ns/1ps

module ifu_predecode (
    input  logic [31:0]       pc,
    input  ifu_pkg::rv_inst_u inst,
    output logic [31:0]       next_pc
);

    import ifu_pkg::*;

    logic              is_jal;
    logic              is_branch;
    logic              br_back;
    logic [addr_w-1:0] j_imm;
    logic [addr_w-1:0] b_imm;

    // ========================================
    // immediates
    // ========================================
    // J view: imm[20|10:1|11|19:12], bit 0 implied zero
    assign j_imm = {
        {11{inst.j.imm20}},
        inst.j.imm20,
        inst.j.imm19_12,
        inst.j.imm11,
        inst.j.imm10_1,
        1'b0
    };

    // B view: imm[12|10:5] ... imm[4:1|11]
    assign b_imm = {
        {19{inst.b.imm12}},
        inst.b.imm12,
        inst.b.imm11,
        inst.b.imm10_5,
        inst.b.imm4_1,
        1'b0
    };

    // ========================================
    // next pc
    // ========================================
    assign is_jal    = (inst.j.opcode == op_jal);
    assign is_branch = (inst.b.opcode == op_branch);
    // negative offset, loop back, predict taken
    assign br_back   = is_branch && inst.b.imm12;

    always_comb begin
        if (is_jal) begin
            next_pc = pc + j_imm;
        end else if (br_back) begin
            next_pc = pc + b_imm;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

endmodule

/* source/ifu_fetch.sv */
// fetch unit
// holds the pc, issues one AXI-lite read at a time and parks each
// returned word with its pc in a single-entry output buffer
// next pc comes from the predecoder side path

`timescale 1ns/1ps

module ifu_fetch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  run,
    // read address channel
    output ifu_pkg::axi_ar_t      ar,
    output logic                  ar_valid,
    input  logic                  ar_ready,
    // read data channel
    input  ifu_pkg::axi_r_t       r,
    input  logic                  r_valid,
    output logic                  r_ready,
    // predecoder
    output logic [31:0]           pd_pc,
    output ifu_pkg::rv_inst_u     pd_inst,
    input  logic [31:0]           pd_next_pc,
    // toward decode
    output ifu_pkg::fetch_out_t   out,
    output logic                  out_valid,
    input  logic                  out_ready
);

    import ifu_pkg::*;

    // ========================================
    // state
    // ========================================
    logic [addr_w-1:0] pc;
    // AR raised but not yet accepted
    logic              ar_hold;
    // AR accepted, waiting on R
    logic              rd_pend;
    fetch_out_t        out_q;
    logic              out_valid_q;

    logic buf_free;
    logic can_issue;
    logic ar_fire;
    logic r_fire;
    logic out_fire;

    // buffer empty or draining this cycle
    assign buf_free  = !out_valid_q || out_ready;
    assign can_issue = run && !ar_hold && !rd_pend && buf_free;

    // once raised, valid stays until accepted
    assign ar_valid  = ar_hold || can_issue;
    assign ar.addr   = pc;

    assign r_ready   = buf_free;

    assign ar_fire   = ar_valid && ar_ready;
    assign r_fire    = r_valid && r_ready;
    assign out_fire  = out_valid_q && out_ready;

    // ========================================
    // request tracking
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            ar_hold <= 1'b0;
            rd_pend <= 1'b0;
        end else begin
            ar_hold <= ar_valid && !ar_ready;
            if (ar_fire) begin
                rd_pend <= 1'b1;
            end else if (r_fire) begin
                rd_pend <= 1'b0;
            end
        end
    end

    // pc moves only when its word comes back
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= pc_rst;
        end else if (r_fire) begin
            pc <= pd_next_pc;
        end
    end

    // ========================================
    // predecode side path
    // ========================================
    assign pd_pc       = pc;
    assign pd_inst.raw = r.data;

    // ========================================
    // output buffer
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
        end else if (r_fire) begin
            out_valid_q <= 1'b1;
        end else if (out_fire) begin
            out_valid_q <= 1'b0;
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (r_fire) begin
            out_q.pc   <= pc;
            out_q.inst <= r.data;
        end
    end

    assign out       = out_q;
    assign out_valid = out_valid_q;

    // ========================================
    // checks
    // ========================================
    // stalled output keeps pair and valid
    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out) && out_valid);

endmodule

/* source/ifu_top.sv */
// instruction fetch front end top
// fetch unit + predecoder + instruction sram
// sram write channels come out as the loader port

`timescale 1ns/1ps

module ifu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,
    // loader write port
    input  ifu_pkg::axi_aw_t    ld_aw,
    input  logic                ld_aw_valid,
    output logic                ld_aw_ready,
    input  ifu_pkg::axi_w_t     ld_w,
    input  logic                ld_w_valid,
    output logic                ld_w_ready,
    output ifu_pkg::axi_b_t     ld_b,
    output logic                ld_b_valid,
    input  logic                ld_b_ready,
    // instruction output
    output ifu_pkg::fetch_out_t out,
    output logic                out_valid,
    input  logic                out_ready
);

    import ifu_pkg::*;

    // fetch <-> sram read channels
    axi_ar_t     ar;
    logic        ar_valid;
    logic        ar_ready;
    axi_r_t      r;
    logic        r_valid;
    logic        r_ready;

    // fetch <-> predecoder
    logic [31:0] pd_pc;
    rv_inst_u    pd_inst;
    logic [31:0] pd_next_pc;

    // ========================================
    // fetch unit
    // ========================================
    ifu_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .ar         (ar),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .r          (r),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .pd_pc      (pd_pc),
        .pd_inst    (pd_inst),
        .pd_next_pc (pd_next_pc),
        .out        (out),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    ifu_predecode u_predecode (
        .pc      (pd_pc),
        .inst    (pd_inst),
        .next_pc (pd_next_pc)
    );

    // ========================================
    // instruction memory
    // ========================================
    ifu_sram u_sram (
        .clk      (clk),
        .rst      (rst),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .aw       (ld_aw),
        .aw_valid (ld_aw_valid),
        .aw_ready (ld_aw_ready),
        .w        (ld_w),
        .w_valid  (ld_w_valid),
        .w_ready  (ld_w_ready),
        .b        (ld_b),
        .b_valid  (ld_b_valid),
        .b_ready  (ld_b_ready)
    );

endmodule

/* dv/tb_clock.sv */
// testbench clock source
// free running, 50/50 duty, period in ns

`timescale 1ns/1ps

module tb_clock #(
    parameter int period = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

endmodule

/* dv/ifu_tb.sv */
// testbench for the instruction fetch front end
// loads programs through the loader write port, runs the fetch unit and
// checks every pc / instruction pair against a local memory model and
// a local next-pc rule

`timescale 1ns/1ps

module ifu_tb;

    import ifu_pkg::*;

    localparam int          tmo  = 200;
    localparam logic [31:0] seed = 32'h6186_3f0b;

    logic       clk;
    logic       rst;
    logic       run;
    axi_aw_t    ld_aw;
    logic       ld_aw_valid;
    logic       ld_aw_ready;
    axi_w_t     ld_w;
    logic       ld_w_valid;
    logic       ld_w_ready;
    axi_b_t     ld_b;
    logic       ld_b_valid;
    logic       ld_b_ready;
    fetch_out_t out;
    logic       out_valid;
    logic       out_ready;

    // expected memory contents, word index from addr[11:2]
    logic [31:0] model [mem_words];

    int errors;
    int tests_run;
    int tests_failed;
    int err_mark;
    bit hung;

    tb_clock #(.period(100)) u_clock (.clk(clk));

    ifu_top uut (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .ld_aw       (ld_aw),
        .ld_aw_valid (ld_aw_valid),
        .ld_aw_ready (ld_aw_ready),
        .ld_w        (ld_w),
        .ld_w_valid  (ld_w_valid),
        .ld_w_ready  (ld_w_ready),
        .ld_b        (ld_b),
        .ld_b_valid  (ld_b_valid),
        .ld_b_ready  (ld_b_ready),
        .out         (out),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

    // ========================================
    // instruction encoding and next pc rule
    // ========================================
    // op-imm opcode in the low bits, never a control transfer
    function automatic logic [31:0] nonctl_word();
        logic [31:0] r;
        r = $urandom;
        return {r[31:7], 7'h13};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    // rs1 = x1, rs2 = x2
    function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], op_branch};
    endfunction

    // jal taken, backward branch taken, else fall through
    function automatic logic [31:0] predict_next(input logic [31:0] pc, input logic [31:0] inst);
        logic [31:0] joff;
        logic [31:0] boff;
        joff = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        boff = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        if (inst[6:0] == op_jal) begin
            return pc + joff;
        end
        if (inst[6:0] == op_branch && inst[31]) begin
            return pc + boff;
        end
        return pc + 32'd4;
    endfunction

    // ========================================
    // drivers and monitors
    // ========================================
    // inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic report_hang(input string what);
        $display("timeout, no %s within %0d cycles", what, tmo);
        errors++;
        hung = 1'b1;
    endtask

    task automatic apply_reset();
        rst       = 1'b1;
        run       = 1'b0;
        out_ready = 1'b0;
        repeat (2) step();
        rst = 1'b0;
    endtask

    // AW, then W, then B; model follows the strobes
    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        int cnt;
        ld_aw.addr  = addr;
        ld_aw_valid = 1'b1;
        cnt = 0;
        while (!ld_aw_ready && cnt < tmo) begin
            step();
            cnt++;
        end
        if (!ld_aw_ready) begin
            report_hang("ld_aw_ready");
            ld_aw_valid = 1'b0;
            return;
        end
        step();
        ld_aw_valid = 1'b0;
        ld_w.data   = data;
        ld_w.strb   = strb;
        ld_w_valid  = 1'b1;
        cnt = 0;
        while (!ld_w_ready && cnt < tmo) begin
            step();
            cnt++;
        end
        if (!ld_w_ready) begin
            report_hang("ld_w_ready");
            ld_w_valid = 1'b0;
            return;
        end
        step();
        ld_w_valid = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                model[addr[11:2]][8*i +: 8] = data[8*i +: 8];
            end
        end
        ld_b_ready = 1'b1;
        cnt = 0;
        while (!ld_b_valid && cnt < tmo) begin
            step();
            cnt++;
        end
        if (!ld_b_valid) begin
            report_hang("ld_b_valid");
            ld_b_ready = 1'b0;
            return;
        end
        if (ld_b.resp !== resp_okay) begin
            $display("[ERROR] ld_b.resp expected %h got %h", resp_okay, ld_b.resp);
            errors++;
        end
        step();
        ld_b_ready = 1'b0;
    endtask

    task automatic load_linear(input int n);
        for (int i = 0; i < n; i++) begin
            write_word(pc_rst + 4 * i, nonctl_word(), 4'hf);
        end
    endtask

    // take one pair off the output port
    task automatic fetch_one(output fetch_out_t got, output bit ok);
        int cnt;
        ok        = 1'b0;
        got       = '0;
        out_ready = 1'b1;
        cnt = 0;
        while (!out_valid && cnt < tmo) begin
            step();
            cnt++;
        end
        if (!out_valid) begin
            report_hang("out_valid");
            out_ready = 1'b0;
            return;
        end
        got = out;
        ok  = 1'b1;
        step();
        out_ready = 1'b0;
    endtask

    // consumer stalls, a held pair must not move
    task automatic hold_off(input int n);
        fetch_out_t held;
        bit         have;
        have      = 1'b0;
        held      = '0;
        out_ready = 1'b0;
        for (int i = 0; i < n; i++) begin
            if (have && !out_valid) begin
                $display("out_valid dropped while out_ready was low");
                errors++;
            end else if (have && out !== held) begin
                $display("[ERROR] out expected %h got %h", held, out);
                errors++;
            end
            if (out_valid && !have) begin
                held = out;
                have = 1'b1;
            end
            step();
        end
    endtask

    task automatic check_pair(input fetch_out_t got, inout logic [31:0] exp_pc);
        logic [31:0] exp_inst;
        exp_inst = model[exp_pc[11:2]];
        if (got.pc !== exp_pc) begin
            $display("[ERROR] out.pc expected %h got %h", exp_pc, got.pc);
            errors++;
        end
        if (got.inst !== exp_inst) begin
            $display("[ERROR] out.inst expected %h got %h", exp_inst, got.inst);
            errors++;
        end
        exp_pc = predict_next(exp_pc, exp_inst);
    endtask

    // walk the expected path from the reset pc
    task automatic collect(input int n, input bit stall);
        fetch_out_t  got;
        bit          ok;
        logic [31:0] exp_pc;
        exp_pc = pc_rst;
        run    = 1'b1;
        for (int k = 0; k < n; k++) begin
            if (stall) begin
                hold_off($urandom_range(6, 0));
            end
            fetch_one(got, ok);
            if (!ok) begin
                break;
            end
            check_pair(got, exp_pc);
        end
        run = 1'b0;
    endtask

    task automatic begin_test();
        err_mark = errors;
        tests_run++;
        apply_reset();
    endtask

    task automatic finish_test(input string name);
        if (errors == err_mark) begin
            $display("%-18s ok", name);
        end else begin
            tests_failed++;
            $display("%-18s failed, %0d errors", name, errors - err_mark);
        end
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic loader_write();
        begin_test();
        for (int i = 0; i < 8; i++) begin
            write_word(pc_rst + 4 * i, nonctl_word(), 4'hf);
            if (out_valid) begin
                $display("out_valid raised while run was low");
                errors++;
            end
        end
        finish_test("loader write");
    endtask

    task automatic sequential_fetch();
        begin_test();
        load_linear(16);
        collect(16, 1'b0);
        finish_test("sequential fetch");
    endtask

    // +0x100 forward, then -0x80 back
    task automatic jal_redirect();
        begin_test();
        write_word(pc_rst, nonctl_word(), 4'hf);
        write_word(pc_rst + 32'h004, enc_jal(5'd1, 21'h000100), 4'hf);
        write_word(pc_rst + 32'h104, nonctl_word(), 4'hf);
        write_word(pc_rst + 32'h108, enc_jal(5'd0, 21'h1fff80), 4'hf);
        write_word(pc_rst + 32'h088, nonctl_word(), 4'hf);
        write_word(pc_rst + 32'h08c, nonctl_word(), 4'hf);
        collect(6, 1'b0);
        finish_test("jal redirect");
    endtask

    // forward beq falls through, backward bne loops to the reset pc
    task automatic branch_predict();
        begin_test();
        write_word(pc_rst, nonctl_word(), 4'hf);
        write_word(pc_rst + 32'h4, enc_branch(3'd0, 13'h0040), 4'hf);
        write_word(pc_rst + 32'h8, enc_branch(3'd1, 13'h1ff8), 4'hf);
        collect(7, 1'b0);
        finish_test("branches");
    endtask

    task automatic back_pressure();
        begin_test();
        load_linear(12);
        collect(12, 1'b1);
        finish_test("back-pressure");
    endtask

    // byte 0 keeps the op-imm opcode from the full write
    task automatic byte_strobes();
        begin_test();
        write_word(pc_rst, nonctl_word(), 4'hf);
        write_word(pc_rst + 32'h4, nonctl_word(), 4'hf);
        write_word(pc_rst, $urandom, 4'b1010);
        write_word(pc_rst + 32'h4, $urandom, 4'b1100);
        collect(2, 1'b0);
        finish_test("byte strobes");
    endtask

    // ========================================
    // sequence and report
    // ========================================
    initial begin
        void'($urandom(seed));
        rst          = 1'b1;
        run          = 1'b0;
        ld_aw        = '0;
        ld_aw_valid  = 1'b0;
        ld_w         = '0;
        ld_w_valid   = 1'b0;
        ld_b_ready   = 1'b0;
        out_ready    = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        hung         = 1'b0;

        loader_write();
        if (!hung) sequential_fetch();
        if (!hung) jal_redirect();
        if (!hung) branch_predict();
        if (!hung) back_pressure();
        if (!hung) byte_strobes();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !hung) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
common/ifu_pkg.sv
sram/ifu_sram.sv
source/ifu_predecode.sv
source/ifu_fetch.sv
source/ifu_top.sv
dv/tb_clock.sv
dv/ifu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the fetch front end testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module ifu_tb -f tb.f -o ifu_sim
./obj_dir/ifu_sim | tee sim.log

if grep -q "TEST PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
